// ==== Bender.yml ====
package:
  name: lc3b_core

sources:
  - include_dirs:
      - .
    files:
      - lc3b_types.sv
      - lc3b_wb_types.sv
      - control_rom.sv
      - lc3b_regfile.sv
      - lc3b_execute.sv
      - lc3b_sequencer.sv
      - lc3b_core.sv
      - target: test
        files:
          - tb_lc3b_core.sv

// ==== control_rom.sv ====
`timescale 1ns/1ps

module control_rom (
	input lc3b_types::lc3b_opcode opcode,
	input logic ir4,
	input logic ir5,
	input logic ir11,
	output lc3b_types::lc3b_control_word ctrl
);

	import lc3b_types::*;

	always_comb begin
		// every opcode starts from a word that changes nothing.
		ctrl.opcode = opcode;
		ctrl.load_regfile = 1'b0;
		ctrl.sr2mux_sel = 2'b00;
		ctrl.sr2mux2_sel = 1'b0;
		ctrl.writemux_sel = 1'b0;
		ctrl.destmux_sel = 1'b0;
		ctrl.bradd2mux_sel = 1'b0;
		ctrl.aluop = alu_pass;
		ctrl.alumux_sel = 1'b0;
		ctrl.mem_addr_mux_sel = 1'b0;
		ctrl.newpcmux_sel = 2'b00;
		ctrl.regfilemux_sel = 3'b000;
		ctrl.load_cc = 1'b0;

		case (opcode)
			op_add: begin
				if (ir5) begin // immediate form uses imm5.
					ctrl.sr2mux_sel = 2'b10;
					ctrl.sr2mux2_sel = 1'b1;
				end
				ctrl.aluop = alu_add;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_and: begin
				if (ir5) begin
					ctrl.sr2mux_sel = 2'b10;
					ctrl.sr2mux2_sel = 1'b1;
				end
				ctrl.aluop = alu_and;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_not: begin
				ctrl.aluop = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_shf: begin
				// the shift amount is imm4, direction and kind come from ir4 and ir5.
				ctrl.sr2mux_sel = 2'b11;
				ctrl.sr2mux2_sel = 1'b1;
				if (!ir4)
					ctrl.aluop = alu_sll;
				else if (!ir5)
					ctrl.aluop = alu_srl;
				else
					ctrl.aluop = alu_sra;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_br: begin
				ctrl.newpcmux_sel = 2'b01; // conditional on the nzp match.
			end

			op_jmp: begin
				ctrl.bradd2mux_sel = 1'b1; // the new PC is BaseR.
			end

			op_jsr: begin
				ctrl.writemux_sel = 1'b1;
				ctrl.regfilemux_sel = 3'b010;
				ctrl.load_regfile = 1'b1;
				if (!ir11)
					ctrl.bradd2mux_sel = 1'b1; // JSRR jumps to BaseR.
			end

			op_lea: begin
				ctrl.regfilemux_sel = 3'b011;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_ldr: begin
				// word address is BaseR plus the offset in words.
				ctrl.sr2mux2_sel = 1'b1;
				ctrl.aluop = alu_add;
				ctrl.regfilemux_sel = 3'b001;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_str: begin
				ctrl.sr2mux2_sel = 1'b1;
				ctrl.destmux_sel = 1'b1; // the stored register sits in the DR field.
				ctrl.aluop = alu_add;
			end

			op_ldb: begin
				ctrl.sr2mux_sel = 2'b01; // byte offset is not scaled.
				ctrl.sr2mux2_sel = 1'b1;
				ctrl.aluop = alu_add;
				ctrl.mem_addr_mux_sel = 1'b1;
				ctrl.regfilemux_sel = 3'b100;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_stb: begin
				ctrl.sr2mux_sel = 2'b01;
				ctrl.sr2mux2_sel = 1'b1;
				ctrl.destmux_sel = 1'b1;
				ctrl.aluop = alu_add;
				ctrl.mem_addr_mux_sel = 1'b1;
			end

			op_trap: begin
				// R7 takes the return address, then the PC comes from the vector table.
				ctrl.writemux_sel = 1'b1;
				ctrl.regfilemux_sel = 3'b010;
				ctrl.load_regfile = 1'b1;
				ctrl.alumux_sel = 1'b1;
				ctrl.newpcmux_sel = 2'b10;
			end

			default: begin
				ctrl = '0; // unknown opcodes fall through as a no-op.
			end
		endcase
	end

endmodule

// ==== lc3b_core.f ====
+incdir+.
lc3b_types.sv
lc3b_wb_types.sv
control_rom.sv
lc3b_regfile.sv
lc3b_execute.sv
lc3b_sequencer.sv
lc3b_core.sv
tb_lc3b_core.sv

// ==== lc3b_core.sv ====
`timescale 1ns/1ps

module lc3b_core (
	input logic clk,
	input logic rst,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output lc3b_wb_types::lc3b_wb_addr wb_adr,
	output lc3b_wb_types::lc3b_wb_sel wb_sel,
	output lc3b_wb_types::lc3b_wb_data wb_wdata,
	input lc3b_wb_types::lc3b_wb_data wb_rdata,
	input logic wb_ack
);

	import lc3b_types::*;

	lc3b_control_word ctrl;
	lc3b_word ir;
	lc3b_word pc;
	lc3b_word mem_addr;
	lc3b_word store_data;
	lc3b_word target_pc;
	lc3b_word mem_rdata;
	lc3b_word rdata_a;
	lc3b_word rdata_b;
	lc3b_word wdata;
	lc3b_reg raddr_a;
	lc3b_reg raddr_b;
	lc3b_reg waddr;
	lc3b_nzp nzp;
	logic rf_write;
	logic cc_load;

	assign cc_load = ctrl.load_cc && rf_write; // flags follow the gated write.

	control_rom control_rom_inst (
		.opcode(lc3b_opcode'(ir[15:12])),
		.ir4(ir[4]),
		.ir5(ir[5]),
		.ir11(ir[11]),
		.ctrl(ctrl)
	);

	lc3b_sequencer lc3b_sequencer_inst (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.nzp(nzp),
		.mem_addr(mem_addr),
		.store_data(store_data),
		.target_pc(target_pc),
		.ir(ir),
		.pc(pc),
		.rf_write(rf_write),
		.mem_rdata(mem_rdata),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_sel(wb_sel),
		.wb_wdata(wb_wdata),
		.wb_rdata(wb_rdata),
		.wb_ack(wb_ack)
	);

	lc3b_execute lc3b_execute_inst (
		.ir(ir),
		.pc(pc),
		.ctrl(ctrl),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.mem_rdata(mem_rdata),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.waddr(waddr),
		.wdata(wdata),
		.mem_addr(mem_addr),
		.store_data(store_data),
		.target_pc(target_pc)
	);

	lc3b_regfile lc3b_regfile_inst (
		.clk(clk),
		.rst(rst),
		.write(rf_write),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.waddr(waddr),
		.wdata(wdata),
		.load_cc(cc_load),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.nzp(nzp)
	);

endmodule

// ==== lc3b_defs.svh ====
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

`define LC3B_WORD_WIDTH 16 // data path and bus width in bits.
`define LC3B_NUM_REGS 8

// the first instruction is fetched from here after reset.
`define LC3B_RESET_PC 16'h0000

// trap vectors are word entries starting at this byte address.
`define LC3B_TRAP_BASE 16'h0000

`endif

// ==== lc3b_execute.sv ====
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module lc3b_execute (
	input lc3b_types::lc3b_word ir,
	input lc3b_types::lc3b_word pc,
	input lc3b_types::lc3b_control_word ctrl,
	input lc3b_types::lc3b_word rdata_a,
	input lc3b_types::lc3b_word rdata_b,
	input lc3b_types::lc3b_word mem_rdata,
	output lc3b_types::lc3b_reg raddr_a,
	output lc3b_types::lc3b_reg raddr_b,
	output lc3b_types::lc3b_reg waddr,
	output lc3b_types::lc3b_word wdata,
	output lc3b_types::lc3b_word mem_addr,
	output lc3b_types::lc3b_word store_data,
	output lc3b_types::lc3b_word target_pc
);

	import lc3b_types::*;

	lc3b_word imm;
	lc3b_word trap_addr;
	lc3b_word alu_a;
	lc3b_word alu_b;
	lc3b_word alu_out;
	lc3b_word pc_offset;
	lc3b_word pc_sum;

	assign raddr_a = ir[8:6]; // SR1 and BaseR share this field.
	assign raddr_b = ctrl.destmux_sel ? ir[11:9] : ir[2:0];
	assign waddr = ctrl.writemux_sel ? lc3b_reg'(`LC3B_NUM_REGS - 1) : ir[11:9];

	always_comb begin
		case (ctrl.sr2mux_sel)
			2'b00: imm = {{9{ir[5]}}, ir[5:0], 1'b0}; // word offset6.
			2'b01: imm = {{10{ir[5]}}, ir[5:0]};
			2'b10: imm = {{11{ir[4]}}, ir[4:0]};
			default: imm = {12'h000, ir[3:0]}; // shift amount.
		endcase
	end

	assign trap_addr = `LC3B_TRAP_BASE + {7'b0, ir[7:0], 1'b0};
	assign alu_a = ctrl.alumux_sel ? trap_addr : rdata_a;
	assign alu_b = ctrl.sr2mux2_sel ? imm : rdata_b;

	always_comb begin
		case (ctrl.aluop)
			alu_add: alu_out = alu_a + alu_b;
			alu_and: alu_out = alu_a & alu_b;
			alu_not: alu_out = ~alu_a;
			alu_sll: alu_out = alu_a << alu_b[3:0];
			alu_srl: alu_out = alu_a >> alu_b[3:0];
			alu_sra: alu_out = $signed(alu_a) >>> alu_b[3:0];
			default: alu_out = alu_a;
		endcase
	end

	// JSR reaches further than BR and LEA.
	assign pc_offset = (ctrl.opcode == op_jsr) ?
		{{4{ir[10]}}, ir[10:0], 1'b0} : {{6{ir[8]}}, ir[8:0], 1'b0};
	assign pc_sum = pc + pc_offset;
	assign target_pc = ctrl.bradd2mux_sel ? rdata_a : pc_sum;

	assign mem_addr = ctrl.mem_addr_mux_sel ? alu_out : {alu_out[15:1], 1'b0};
	assign store_data = rdata_b;

	always_comb begin
		case (ctrl.regfilemux_sel)
			3'b001: wdata = mem_rdata;
			3'b010: wdata = pc; // already the return address.
			3'b011: wdata = pc_sum;
			3'b100: wdata = {8'h00, mem_rdata[7:0]};
			default: wdata = alu_out;
		endcase
	end

endmodule

// ==== lc3b_regfile.sv ====
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module lc3b_regfile (
	input logic clk,
	input logic rst,
	input logic write,
	input lc3b_types::lc3b_reg raddr_a,
	input lc3b_types::lc3b_reg raddr_b,
	input lc3b_types::lc3b_reg waddr,
	input lc3b_types::lc3b_word wdata,
	input logic load_cc,
	output lc3b_types::lc3b_word rdata_a,
	output lc3b_types::lc3b_word rdata_b,
	output lc3b_types::lc3b_nzp nzp
);

	import lc3b_types::*;

	lc3b_word regs [`LC3B_NUM_REGS];

	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++)
				regs[i] <= '0;
			nzp <= '0;
		end else if (write) begin
			regs[waddr] <= wdata;
			if (load_cc)
				nzp <= {wdata[15], wdata == '0, !wdata[15] && wdata != '0};
		end
	end

	// condition codes only move together with a register write.
	a_cc_with_write: assert property (@(posedge clk) disable iff (rst) load_cc |-> write);

endmodule

// ==== lc3b_sequencer.sv ====
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module lc3b_sequencer (
	input logic clk,
	input logic rst,
	input lc3b_types::lc3b_control_word ctrl,
	input lc3b_types::lc3b_nzp nzp,
	input lc3b_types::lc3b_word mem_addr,
	input lc3b_types::lc3b_word store_data,
	input lc3b_types::lc3b_word target_pc,
	output lc3b_types::lc3b_word ir,
	output lc3b_types::lc3b_word pc,
	output logic rf_write,
	output lc3b_types::lc3b_word mem_rdata,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output lc3b_wb_types::lc3b_wb_addr wb_adr,
	output lc3b_wb_types::lc3b_wb_sel wb_sel,
	output lc3b_wb_types::lc3b_wb_data wb_wdata,
	input lc3b_wb_types::lc3b_wb_data wb_rdata,
	input logic wb_ack
);

	import lc3b_types::*;

	typedef enum logic [1:0] {s_fetch, s_exec, s_mem} state_t;

	state_t state;
	logic is_byte;
	logic is_load;
	logic is_store;
	logic mem_op;
	logic taken;
	lc3b_word next_pc;

	assign is_byte = (ctrl.opcode == op_ldb) || (ctrl.opcode == op_stb);
	assign is_load = (ctrl.opcode == op_ldr) || (ctrl.opcode == op_ldb);
	assign is_store = (ctrl.opcode == op_str) || (ctrl.opcode == op_stb);
	assign mem_op = is_load || is_store || (ctrl.opcode == op_trap);

	// branches test the IR nzp field, jumps and subroutine calls always go.
	assign taken = ((ctrl.newpcmux_sel == 2'b01) && |(ir[11:9] & nzp)) ||
		(ctrl.opcode == op_jmp) || (ctrl.opcode == op_jsr);
	assign next_pc = taken ? target_pc : pc;

	// loads write back on the data ack, everything else at the end of EXEC.
	assign rf_write = ctrl.load_regfile &&
		((state == s_exec && !is_load) || (state == s_mem && wb_stb && wb_ack && is_load));

	// an odd LDB byte arrives in the upper lane and is moved down.
	assign mem_rdata = (ctrl.opcode == op_ldb && mem_addr[0]) ?
		{wb_rdata[7:0], wb_rdata[15:8]} : wb_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_fetch;
			pc <= `LC3B_RESET_PC;
			ir <= '0;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			case (state)
				s_fetch: begin
					if (!wb_cyc) begin
						wb_cyc <= 1'b1; // open the instruction read.
						wb_stb <= 1'b1;
						wb_we <= 1'b0;
						wb_adr <= pc;
						wb_sel <= 2'b11;
					end else if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						ir <= wb_rdata;
						pc <= pc + 16'd2;
						state <= s_exec;
					end
				end
				s_exec: begin
					pc <= next_pc;
					if (mem_op) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= is_store;
						wb_adr <= {mem_addr[15:1], 1'b0};
						wb_sel <= is_byte ? (mem_addr[0] ? 2'b10 : 2'b01) : 2'b11;
						wb_wdata <= is_byte ? {2{store_data[7:0]}} : store_data;
						state <= s_mem;
					end else begin
						state <= s_fetch;
					end
				end
				s_mem: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
						if (ctrl.newpcmux_sel == 2'b10)
							pc <= wb_rdata; // trap vector read.
						state <= s_fetch;
					end
				end
				default: state <= s_fetch;
			endcase
		end
	end

	// an acknowledged request releases both the cycle and the strobe.
	a_ack_release: assert property (@(posedge clk) disable iff (rst)
		wb_stb && wb_ack |=> !wb_cyc && !wb_stb);

	// a pending request holds its address and direction until the slave answers.
	a_req_stable: assert property (@(posedge clk) disable iff (rst)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_sel));

	a_fetch_read: assert property (@(posedge clk) disable iff (rst)
		state == s_fetch |-> !wb_we);

endmodule

// ==== lc3b_types.sv ====
`include "lc3b_defs.svh"

package lc3b_types;

	typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_word;
	typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp; // negative, zero, positive.

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_not  = 4'b1001,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluops;

	typedef struct packed {
		lc3b_opcode opcode;
		logic load_regfile;
		logic [1:0] sr2mux_sel; // immediate kind for the second operand.
		logic sr2mux2_sel;
		logic writemux_sel;
		logic destmux_sel;
		logic bradd2mux_sel;
		lc3b_aluops aluop;
		logic alumux_sel;
		logic mem_addr_mux_sel;
		logic [1:0] newpcmux_sel;
		logic [2:0] regfilemux_sel;
		logic load_cc;
	} lc3b_control_word;

endpackage

// ==== lc3b_wb_types.sv ====
`include "lc3b_defs.svh"

package lc3b_wb_types;

	// the bus carries byte addresses and one lane per byte of a word.
	typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_wb_addr;
	typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_wb_data;
	typedef logic [`LC3B_WORD_WIDTH/8-1:0] lc3b_wb_sel;

endpackage

// ==== tb_lc3b_core.sv ====
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module tb_lc3b_core;

	import lc3b_types::*;
	import lc3b_wb_types::*;

	localparam lc3b_word data_base = 16'h0100; // operands here, results from data_base + 32.
	localparam int halt_timeout = 5000;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	lc3b_wb_addr wb_adr;
	lc3b_wb_sel wb_sel;
	lc3b_wb_data wb_wdata;
	lc3b_wb_data wb_rdata;
	logic wb_ack;

	logic [7:0] mem [65536];
	lc3b_word asm_pc;
	lc3b_word halt_adr;
	bit halt_seen;
	int ack_max;
	int checks;
	int errors;
	lc3b_wb_addr log_adr [$];
	lc3b_wb_sel log_sel [$];
	lc3b_wb_data log_data [$];
	lc3b_wb_addr exp_adr [$];
	lc3b_wb_sel exp_sel [$];

	// the request as first presented, compared again when it is acknowledged.
	bit busy;
	int wait_cnt;
	int wait_len;
	lc3b_wb_addr req_adr;
	lc3b_wb_sel req_sel;
	lc3b_wb_data req_data;
	logic req_we;

	// operands shared by the ALU test and its rerun with a stalling bus.
	lc3b_word op_a;
	lc3b_word op_b;
	logic [4:0] imm_a;
	logic [4:0] imm_b;

	lc3b_core lc3b_core_inst (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_sel(wb_sel),
		.wb_wdata(wb_wdata),
		.wb_rdata(wb_rdata),
		.wb_ack(wb_ack)
	);

	always #2 clk = ~clk;

	task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input lc3b_wb_addr got, input lc3b_wb_addr exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_sel(input string name, input lc3b_wb_sel got, input lc3b_wb_sel exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH time %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// memory slave: samples the bus at the edge and answers 1 ns later.
	always @(posedge clk) begin
		logic do_ack;
		lc3b_wb_data rd;
		do_ack = 1'b0;
		rd = wb_rdata;
		if (rst || wb_ack) begin
			busy = 1'b0; // an ack seen at this edge ends the request.
		end else if (wb_stb) begin
			if (!busy) begin
				busy = 1'b1;
				wait_cnt = 0;
				wait_len = (ack_max > 0) ? $urandom_range(ack_max, 0) : 0;
				req_adr = wb_adr;
				req_sel = wb_sel;
				req_we = wb_we;
				req_data = wb_wdata;
			end
			if (wait_cnt == wait_len)
				do_ack = 1'b1;
			else
				wait_cnt++;
		end
		if (do_ack) begin
			check_addr("wb_adr", wb_adr, req_adr);
			check_sel("wb_sel", wb_sel, req_sel);
			checks++;
			if (wb_we !== req_we) begin
				errors++;
				$display("wb_we changed at time %0t while the request waited for ack", $time);
			end
			checks++;
			if (wb_cyc !== 1'b1) begin
				errors++;
				$display("wb_stb was high without wb_cyc at time %0t", $time);
			end
			if (wb_we) begin
				check_word("wb_wdata", wb_wdata, req_data);
				if (wb_sel[0])
					mem[wb_adr & 16'hfffe] = wb_wdata[7:0];
				if (wb_sel[1])
					mem[wb_adr | 16'h0001] = wb_wdata[15:8];
				log_adr.push_back(wb_adr);
				log_sel.push_back(wb_sel);
				log_data.push_back(wb_wdata);
			end else begin
				rd = {mem[wb_adr | 16'h0001], mem[wb_adr & 16'hfffe]}; // little endian.
				if (wb_adr == halt_adr)
					halt_seen = 1'b1;
			end
		end
		#1;
		wb_ack = do_ack;
		wb_rdata = rd;
	end

	function automatic logic [7:0] fill_byte(input lc3b_word a);
		return a[7:0] ^ a[15:8] ^ 8'h5a;
	endfunction

	function automatic lc3b_word mem_word(input lc3b_word a);
		return {mem[a | 16'h0001], mem[a & 16'hfffe]};
	endfunction

	task automatic put_word(input lc3b_word a, input lc3b_word w);
		mem[a] = w[7:0];
		mem[a + 16'd1] = w[15:8];
	endtask

	task automatic emit(input lc3b_word w);
		put_word(asm_pc, w);
		asm_pc += 16'd2;
	endtask

	// word offset from the instruction about to be emitted to target.
	function automatic lc3b_word offset_to(input lc3b_word target);
		return lc3b_word'($signed(target - asm_pc - 16'd2) >>> 1);
	endfunction

	function automatic lc3b_word reg_form(input logic [3:0] op, input lc3b_reg a,
		input lc3b_reg b, input logic [5:0] low);
		return {op, a, b, low};
	endfunction

	function automatic lc3b_word pc_form(input logic [3:0] op, input logic [2:0] f,
		input lc3b_word off);
		return {op, f, off[8:0]};
	endfunction

	function automatic logic [5:0] imm5(input int v);
		return {1'b1, 5'(v)};
	endfunction

	task automatic halt_here;
		halt_adr = asm_pc;
		emit(pc_form(op_br, 3'b111, 16'hffff)); // branch to itself.
	endtask

	task automatic expect_write(input lc3b_wb_addr a, input lc3b_wb_sel s);
		exp_adr.push_back(a);
		exp_sel.push_back(s);
	endtask

	task automatic start_program;
		int a;
		@(posedge clk);
		#1;
		rst = 1'b1;
		for (a = 0; a < 65536; a++)
			mem[a] = fill_byte(lc3b_word'(a));
		asm_pc = `LC3B_RESET_PC;
		halt_seen = 1'b0;
		ack_max = 0;
		log_adr.delete();
		log_sel.delete();
		log_data.delete();
		exp_adr.delete();
		exp_sel.delete();
	endtask

	task automatic run_program;
		int n;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		n = 0;
		while (!halt_seen && n < halt_timeout) begin
			@(posedge clk);
			n++;
		end
		if (!halt_seen) begin
			errors++;
			$display("program did not reach the halt address %h within %0d cycles",
				halt_adr, halt_timeout);
		end
	endtask

	task automatic check_write_log;
		int i;
		checks++;
		if (log_adr.size() != exp_adr.size()) begin
			errors++;
			$display("the program made %0d bus writes where %0d were expected",
				log_adr.size(), exp_adr.size());
		end else begin
			for (i = 0; i < exp_adr.size(); i++) begin
				check_addr("write address", log_adr[i], exp_adr[i]);
				check_sel("write select", log_sel[i], exp_sel[i]);
			end
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		$display("test %-18s %0d errors", name, errors - start_errors);
	endtask

	task automatic alu_program;
		int i;
		start_program();
		put_word(data_base, op_a);
		put_word(data_base + 16'd2, op_b);
		emit(pc_form(op_lea, 3'd6, offset_to(data_base)));
		emit(reg_form(op_ldr, 3'd1, 3'd6, 6'd0));
		emit(reg_form(op_ldr, 3'd2, 3'd6, 6'd1));
		emit(reg_form(op_add, 3'd3, 3'd1, 6'd2));
		emit(reg_form(op_str, 3'd3, 3'd6, 6'd16));
		emit(reg_form(op_add, 3'd3, 3'd1, {1'b1, imm_a}));
		emit(reg_form(op_str, 3'd3, 3'd6, 6'd17));
		emit(reg_form(op_and, 3'd3, 3'd1, 6'd2));
		emit(reg_form(op_str, 3'd3, 3'd6, 6'd18));
		emit(reg_form(op_and, 3'd3, 3'd1, {1'b1, imm_b}));
		emit(reg_form(op_str, 3'd3, 3'd6, 6'd19));
		emit(reg_form(op_not, 3'd3, 3'd1, 6'h3f));
		emit(reg_form(op_str, 3'd3, 3'd6, 6'd20));
		halt_here();
		for (i = 0; i < 5; i++)
			expect_write(data_base + 16'd32 + 16'(2 * i), 2'b11);
	endtask

	task automatic alu_results;
		lc3b_word d;
		d = data_base + 16'd32;
		check_write_log();
		check_word("add register", mem_word(d), op_a + op_b);
		check_word("add immediate", mem_word(d + 16'd2), op_a + {{11{imm_a[4]}}, imm_a});
		check_word("and register", mem_word(d + 16'd4), op_a & op_b);
		check_word("and immediate", mem_word(d + 16'd6), op_a & {{11{imm_b[4]}}, imm_b});
		check_word("not", mem_word(d + 16'd8), ~op_a);
	endtask

	task automatic alu_ops;
		int e;
		e = errors;
		op_a = lc3b_word'($urandom());
		op_b = lc3b_word'($urandom());
		imm_a = 5'($urandom());
		imm_b = 5'($urandom());
		alu_program();
		run_program();
		alu_results();
		finish_test("alu_ops", e);
	endtask

	task automatic shift_ops;
		int e;
		lc3b_word a;
		logic [3:0] n1;
		logic [3:0] n2;
		logic [3:0] n3;
		lc3b_word d;
		e = errors;
		d = data_base;
		a = lc3b_word'($urandom()) | 16'h8000; // negative, so the arithmetic shift fills ones.
		n1 = 4'($urandom());
		n2 = 4'($urandom());
		n3 = 4'($urandom());
		start_program();
		put_word(d, a);
		emit(pc_form(op_lea, 3'd6, offset_to(d)));
		emit(reg_form(op_ldr, 3'd1, 3'd6, 6'd0));
		emit(reg_form(op_shf, 3'd3, 3'd1, {2'b00, n1}));
		emit(reg_form(op_str, 3'd3, 3'd6, 6'd16));
		emit(reg_form(op_shf, 3'd4, 3'd1, {2'b01, n2}));
		emit(reg_form(op_str, 3'd4, 3'd6, 6'd17));
		emit(reg_form(op_shf, 3'd5, 3'd1, {2'b11, n3}));
		emit(reg_form(op_str, 3'd5, 3'd6, 6'd18));
		halt_here();
		expect_write(d + 16'd32, 2'b11);
		expect_write(d + 16'd34, 2'b11);
		expect_write(d + 16'd36, 2'b11);
		run_program();
		check_write_log();
		check_word("shift left", mem_word(d + 16'd32), a << n1);
		check_word("shift right logical", mem_word(d + 16'd34), a >> n2);
		check_word("shift right arithmetic", mem_word(d + 16'd36),
			(a >> n3) | ~(16'hffff >> n3));
		finish_test("shift_ops", e);
	endtask

	task automatic branch_lea;
		int e;
		logic [8:0] loff;
		lc3b_word lea_exp;
		e = errors;
		loff = 9'($urandom());
		start_program();
		emit(pc_form(op_lea, 3'd6, offset_to(data_base)));
		// negative result: BRzp falls through, BRn skips the +4.
		emit(reg_form(op_add, 3'd1, 3'd0, imm5(-3)));
		emit(pc_form(op_br, 3'b011, 16'd1));
		emit(reg_form(op_add, 3'd1, 3'd1, imm5(2)));
		emit(pc_form(op_br, 3'b100, 16'd1));
		emit(reg_form(op_add, 3'd1, 3'd1, imm5(4)));
		emit(reg_form(op_str, 3'd1, 3'd6, 6'd16));
		emit(reg_form(op_and, 3'd2, 3'd2, imm5(0)));
		emit(pc_form(op_br, 3'b010, 16'd1));
		emit(reg_form(op_add, 3'd2, 3'd2, imm5(7)));
		emit(reg_form(op_add, 3'd2, 3'd2, imm5(3)));
		emit(pc_form(op_br, 3'b110, 16'd1));
		emit(reg_form(op_add, 3'd2, 3'd2, imm5(4)));
		emit(reg_form(op_str, 3'd2, 3'd6, 6'd17));
		emit(reg_form(op_add, 3'd3, 3'd0, imm5(6)));
		emit(pc_form(op_br, 3'b001, 16'd1));
		emit(reg_form(op_add, 3'd3, 3'd3, imm5(1)));
		emit(pc_form(op_br, 3'b110, 16'd1));
		emit(reg_form(op_add, 3'd3, 3'd3, imm5(-16)));
		emit(reg_form(op_str, 3'd3, 3'd6, 6'd18));
		lea_exp = asm_pc + 16'd2 + {{6{loff[8]}}, loff, 1'b0};
		emit(pc_form(op_lea, 3'd4, {7'b0, loff}));
		emit(reg_form(op_str, 3'd4, 3'd6, 6'd19));
		halt_here();
		expect_write(data_base + 16'd32, 2'b11);
		expect_write(data_base + 16'd34, 2'b11);
		expect_write(data_base + 16'd36, 2'b11);
		expect_write(data_base + 16'd38, 2'b11);
		run_program();
		check_write_log();
		check_word("n path marker", mem_word(data_base + 16'd32), 16'(-3 + 2));
		check_word("z path marker", mem_word(data_base + 16'd34), 16'(3 + 4));
		check_word("p path marker", mem_word(data_base + 16'd36), 16'(6 - 16));
		check_word("lea target", mem_word(data_base + 16'd38), lea_exp);
		finish_test("branch_lea", e);
	endtask

	task automatic subroutine_calls;
		int e;
		lc3b_word sub1;
		lc3b_word sub2;
		lc3b_word trap_sub;
		lc3b_word off;
		lc3b_word ret1;
		lc3b_word ret2;
		lc3b_word ret3;
		logic [7:0] tvec;
		e = errors;
		sub1 = 16'h0040;
		sub2 = 16'h0050;
		trap_sub = 16'h0060;
		tvec = 8'h7f; // table entry at 0x00fe, clear of the code.
		start_program();
		put_word(`LC3B_TRAP_BASE + {7'b0, tvec, 1'b0}, trap_sub);
		emit(pc_form(op_lea, 3'd6, offset_to(data_base)));
		off = offset_to(sub1);
		emit({op_jsr, 1'b1, off[10:0]});
		ret1 = asm_pc;
		emit(pc_form(op_lea, 3'd5, offset_to(sub2)));
		emit(reg_form(op_jsr, 3'd0, 3'd5, 6'd0)); // JSRR through R5.
		ret2 = asm_pc;
		emit({op_trap, 4'h0, tvec});
		ret3 = asm_pc;
		halt_here();
		asm_pc = sub1;
		emit(reg_form(op_str, 3'd7, 3'd6, 6'd16));
		emit(reg_form(op_jmp, 3'd0, 3'd7, 6'd0));
		asm_pc = sub2;
		emit(reg_form(op_str, 3'd7, 3'd6, 6'd17));
		emit(pc_form(op_lea, 3'd4, offset_to(ret2)));
		emit(reg_form(op_jmp, 3'd0, 3'd4, 6'd0));
		asm_pc = trap_sub;
		emit(reg_form(op_str, 3'd7, 3'd6, 6'd18));
		emit(reg_form(op_jmp, 3'd0, 3'd7, 6'd0));
		expect_write(data_base + 16'd32, 2'b11);
		expect_write(data_base + 16'd34, 2'b11);
		expect_write(data_base + 16'd36, 2'b11);
		run_program();
		check_write_log();
		check_word("jsr return", mem_word(data_base + 16'd32), ret1);
		check_word("jsrr return", mem_word(data_base + 16'd34), ret2);
		check_word("trap return", mem_word(data_base + 16'd36), ret3);
		finish_test("subroutine_calls", e);
	endtask

	task automatic byte_access;
		int e;
		lc3b_word w;
		lc3b_word d;
		e = errors;
		d = data_base;
		w = lc3b_word'($urandom()) | 16'h8080; // top bits set in both bytes.
		start_program();
		put_word(d, w);
		emit(pc_form(op_lea, 3'd6, offset_to(d)));
		emit(reg_form(op_ldb, 3'd1, 3'd6, 6'd0));
		emit(reg_form(op_ldb, 3'd2, 3'd6, 6'd1));
		emit(reg_form(op_str, 3'd1, 3'd6, 6'd16));
		emit(reg_form(op_str, 3'd2, 3'd6, 6'd17));
		emit(reg_form(op_stb, 3'd1, 3'd6, 6'd25));
		emit(reg_form(op_stb, 3'd2, 3'd6, 6'd26));
		emit(reg_form(op_ldr, 3'd3, 3'd6, 6'd12));
		emit(reg_form(op_str, 3'd3, 3'd6, 6'd18));
		halt_here();
		expect_write(d + 16'd32, 2'b11);
		expect_write(d + 16'd34, 2'b11);
		expect_write(d + 16'd24, 2'b10);
		expect_write(d + 16'd26, 2'b01);
		expect_write(d + 16'd36, 2'b11);
		run_program();
		check_write_log();
		if (log_data.size() == 5) begin
			check_word("odd byte lane", {8'h00, log_data[2][15:8]}, {8'h00, w[7:0]});
			check_word("even byte lane", {8'h00, log_data[3][7:0]}, {8'h00, w[15:8]});
		end
		check_word("ldb even", mem_word(d + 16'd32), {8'h00, w[7:0]});
		check_word("ldb odd", mem_word(d + 16'd34), {8'h00, w[15:8]});
		check_word("stb odd word", mem_word(d + 16'd24), {w[7:0], fill_byte(d + 16'd24)});
		check_word("stb even word", mem_word(d + 16'd26), {fill_byte(d + 16'd27), w[15:8]});
		check_word("ldr round trip", mem_word(d + 16'd36), {w[7:0], fill_byte(d + 16'd24)});
		finish_test("byte_access", e);
	endtask

	task automatic alu_with_stalls;
		int e;
		e = errors;
		alu_program();
		ack_max = 5;
		run_program();
		alu_results();
		finish_test("alu_with_stalls", e);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		wb_ack = 1'b0;
		wb_rdata = '0;
		ack_max = 0;
		halt_seen = 1'b0;
		halt_adr = 16'hffff;
		busy = 1'b0;
		checks = 0;
		errors = 0;
		void'($urandom(56244));
		repeat (2) @(posedge clk);
		alu_ops();
		shift_ops();
		branch_lea();
		subroutine_calls();
		byte_access();
		alu_with_stalls();
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
